/* core_pkg.sv */
////////////////////
// core glue package
// shared widths, bridge register map, pixel types and
// the opcode enum for the reset registers
////////////////////

package core_pkg;

  ////////////////////
  // bridge bus

  localparam int bridge_addr_w = 32;

  // reset registers, one word each
  localparam logic [bridge_addr_w-1:0] reset_reg_base = 32'h1000_0000;
  localparam logic [bridge_addr_w-1:0] reset_plus_addr = reset_reg_base + 32'd4;

  typedef enum logic [1:0] {
    reg_menu_reset,
    reg_reset_plus,
    reg_none
  } reset_reg_e;

  ////////////////////
  // reset timing

  localparam int menu_reset_len = 15;
  localparam int menu_cnt_w = $clog2(menu_reset_len + 1);
  localparam int reset_hold_cycles = 65535;
  localparam int hold_cnt_w = $clog2(reset_hold_cycles + 1);

  // face_start in the controller key bitmap
  localparam int start_key_bit = 15;

  ////////////////////
  // rtc, data slots, video

  localparam int clks_per_second = 57_120_000;

  localparam int read_stretch_cycles = 7;
  localparam int stretch_cnt_w = $clog2(read_stretch_cycles + 1);

  localparam int datatable_addr_w = 10;

  typedef logic [15:0] rgb565_t;
  typedef logic [23:0] rgb888_t;

endpackage

/* core_reset_ctrl.sv */
////////////////////
// core reset control
// bridge reset registers, start button sync and the
// long core reset hold, plus the download hold
////////////////////

`timescale 1ns/1ps

module core_reset_ctrl import core_pkg::*; (
  input  logic                     clk_sys_57_12,
  input  logic                     reset,
  input  logic                     host_reset_n,
  input  logic [bridge_addr_w-1:0] bridge_addr,
  input  logic                     bridge_wr,
  input  logic [bridge_addr_w-1:0] bridge_wr_data,
  input  logic                     start_key,
  input  logic                     dataslot_requestwrite,
  input  logic                     dataslot_allcomplete,
  output logic                     core_reset
);

  reset_reg_e              reg_sel;
  logic [menu_cnt_w-1:0]   menu_cnt;
  logic                    enable_reset_plus;
  logic [1:0]              start_sync;
  logic                    reset_trigger;
  logic                    trigger_q;
  logic [hold_cnt_w-1:0]   hold_cnt;
  logic                    download;

  // bridge write decode
  always_comb begin
    reg_sel = reg_none;
    if (bridge_wr) begin
      if (bridge_addr == reset_reg_base) reg_sel = reg_menu_reset;
      else if (bridge_addr == reset_plus_addr) reg_sel = reg_reset_plus;
    end
  end

  ////////////////////
  // bridge registers

  always_ff @(posedge clk_sys_57_12) begin
    if (reset) begin
      menu_cnt          <= '0;
      enable_reset_plus <= 1'b0;
    end else begin
      if (reg_sel == reg_menu_reset) menu_cnt <= menu_cnt_w'(menu_reset_len);
      else if (menu_cnt != '0) menu_cnt <= menu_cnt - 1'b1;
      if (reg_sel == reg_reset_plus) enable_reset_plus <= bridge_wr_data[0];
    end
  end

  // start key comes straight from the pad
  always_ff @(posedge clk_sys_57_12) begin
    if (reset) start_sync <= '0;
    else start_sync <= {start_sync[0], start_key};
  end

  assign reset_trigger = (menu_cnt == menu_cnt_w'(1)) || (start_sync[1] && enable_reset_plus);

  ////////////////////
  // hold timer and download flag

  always_ff @(posedge clk_sys_57_12) begin
    if (reset) begin
      trigger_q <= 1'b0;
      hold_cnt  <= '0;
      download  <= 1'b0;
    end else begin
      trigger_q <= reset_trigger;
      // only the rising edge restarts the hold
      if (reset_trigger && !trigger_q) hold_cnt <= hold_cnt_w'(reset_hold_cycles);
      else if (hold_cnt != '0) hold_cnt <= hold_cnt - 1'b1;
      if (dataslot_requestwrite) download <= 1'b1;
      else if (dataslot_allcomplete) download <= 1'b0;
    end
  end

  // system reset also holds the core
  assign core_reset = reset || !host_reset_n || download || (hold_cnt != '0);

  a_no_reload_while_held: assert property (@(posedge clk_sys_57_12) disable iff (reset)
    (reset_trigger && trigger_q) |=> hold_cnt != hold_cnt_w'(reset_hold_cycles));

endmodule

/* core_top.sv */
////////////////////
// core top level
// reset control, rtc, data slot glue and video output
////////////////////

`timescale 1ns/1ps

module core_top import core_pkg::*; #(
  parameter int CLKS_PER_SEC = clks_per_second
) (
  input  logic                        clk_sys_57_12,
  input  logic                        reset,
  input  logic                        host_reset_n,
  input  logic [bridge_addr_w-1:0]    bridge_addr,
  input  logic                        bridge_wr,
  input  logic [bridge_addr_w-1:0]    bridge_wr_data,
  input  logic [31:0]                 cont1_key,
  input  logic                        dataslot_requestwrite,
  input  logic                        dataslot_allcomplete,
  input  logic                        rtc_valid,
  input  logic [bridge_addr_w-1:0]    rtc_epoch_seconds,
  input  logic                        core_request_read,
  input  logic [bridge_addr_w-1:0]    ram_data_address,
  input  logic [15:0]                 target_dataslot_id,
  input  logic [bridge_addr_w-1:0]    datatable_q,
  input  logic                        target_dataslot_done,
  input  rgb565_t                     rgb565,
  input  logic                        hsync,
  input  logic                        vsync,
  input  logic                        de,
  output logic                        core_reset,
  output logic [bridge_addr_w-1:0]    unix_seconds,
  output logic                        target_dataslot_read,
  output logic [bridge_addr_w-1:0]    bridge_ram_address,
  output logic [datatable_addr_w-1:0] datatable_addr,
  output logic [bridge_addr_w-1:0]    active_file_size,
  output logic                        complete_trigger,
  output rgb888_t                     video_rgb,
  output logic                        video_hs,
  output logic                        video_vs,
  output logic                        video_de
);

  core_reset_ctrl reset_ctrl_i (
    .clk_sys_57_12, .reset, .host_reset_n, .bridge_addr, .bridge_wr, .bridge_wr_data,
    .start_key(cont1_key[start_key_bit]),
    .dataslot_requestwrite, .dataslot_allcomplete, .core_reset
  );

  rtc_seconds #(.CLKS_PER_SEC(CLKS_PER_SEC)) rtc_i (
    .clk_sys_57_12, .reset, .rtc_valid, .rtc_epoch_seconds, .unix_seconds
  );

  dataslot_read_ctrl dataslot_i (
    .clk_sys_57_12, .reset, .core_request_read, .ram_data_address, .target_dataslot_id,
    .datatable_q, .target_dataslot_done, .target_dataslot_read, .bridge_ram_address,
    .datatable_addr, .active_file_size, .complete_trigger
  );

  video_out video_i (
    .clk_sys_57_12, .reset, .rgb565, .hsync, .vsync, .de,
    .video_rgb, .video_hs, .video_vs, .video_de
  );

endmodule

/* dataslot_read_ctrl.sv */
////////////////////
// data slot read glue
// stretches the read request, latches the ram address,
// fetches the slot file size and pulses on completion
////////////////////

`timescale 1ns/1ps

module dataslot_read_ctrl import core_pkg::*; (
  input  logic                        clk_sys_57_12,
  input  logic                        reset,
  input  logic                        core_request_read,
  input  logic [bridge_addr_w-1:0]    ram_data_address,
  input  logic [15:0]                 target_dataslot_id,
  input  logic [bridge_addr_w-1:0]    datatable_q,
  input  logic                        target_dataslot_done,
  output logic                        target_dataslot_read,
  output logic [bridge_addr_w-1:0]    bridge_ram_address,
  output logic [datatable_addr_w-1:0] datatable_addr,
  output logic [bridge_addr_w-1:0]    active_file_size,
  output logic                        complete_trigger
);

  logic                     request_q;
  logic [stretch_cnt_w-1:0] stretch_cnt;
  logic                     done_q;

  ////////////////////
  // read strobe stretch

  always_ff @(posedge clk_sys_57_12) begin
    if (reset) begin
      request_q   <= 1'b0;
      stretch_cnt <= '0;
    end else begin
      request_q <= core_request_read;
      if (core_request_read && !request_q) stretch_cnt <= stretch_cnt_w'(read_stretch_cycles);
      else if (stretch_cnt != '0) stretch_cnt <= stretch_cnt - 1'b1;
    end
  end

  assign target_dataslot_read = (stretch_cnt != '0);

  // destination address, held between requests
  always_ff @(posedge clk_sys_57_12) begin
    if (core_request_read) bridge_ram_address <= ram_data_address;
    active_file_size <= datatable_q;
  end

  // size lives in the odd word of each slot entry
  always_ff @(posedge clk_sys_57_12) begin
    if (reset) begin
      datatable_addr   <= '0;
      done_q           <= 1'b0;
      complete_trigger <= 1'b0;
    end else begin
      datatable_addr   <= {target_dataslot_id[datatable_addr_w-2:0], 1'b1};
      done_q           <= target_dataslot_done;
      complete_trigger <= target_dataslot_done && !done_q;
    end
  end

  a_single_complete: assert property (@(posedge clk_sys_57_12) disable iff (reset)
    complete_trigger |=> !complete_trigger);

endmodule

/* files.f */
core_pkg.sv
core_reset_ctrl.sv
rtc_seconds.sv
dataslot_read_ctrl.sv
video_out.sv
core_top.sv
tb_core_top.sv

/* rtc_seconds.sv */
////////////////////
// rtc seconds counter
// free running unix seconds, loaded from the host epoch
////////////////////

`timescale 1ns/1ps

module rtc_seconds import core_pkg::*; #(
  parameter int CLKS_PER_SEC = clks_per_second
) (
  input  logic                     clk_sys_57_12,
  input  logic                     reset,
  input  logic                     rtc_valid,
  input  logic [bridge_addr_w-1:0] rtc_epoch_seconds,
  output logic [bridge_addr_w-1:0] unix_seconds
);

  logic                     valid_q;
  logic                     valid_rise;
  logic [bridge_addr_w-1:0] tick_cnt;

  assign valid_rise = rtc_valid && !valid_q;

  always_ff @(posedge clk_sys_57_12) begin
    if (reset) begin
      valid_q      <= 1'b0;
      tick_cnt     <= '0;
      unix_seconds <= '0;
    end else begin
      valid_q <= rtc_valid;
      if (valid_rise) begin
        // fresh epoch from the host
        unix_seconds <= rtc_epoch_seconds;
        tick_cnt     <= bridge_addr_w'(CLKS_PER_SEC);
      end else if (tick_cnt != '0) begin
        tick_cnt <= tick_cnt - 1'b1;
      end else begin
        // one second elapsed
        tick_cnt     <= bridge_addr_w'(CLKS_PER_SEC);
        unix_seconds <= unix_seconds + 1'b1;
      end
    end
  end

endmodule

/* run_sim.sh */
#!/bin/sh
# build and run the core glue testbench with Verilator
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --assert --top-module tb_core_top -f files.f
./obj_dir/Vtb_core_top | tee sim.log
if grep -q "sim passed" sim.log; then
  echo "PASS"
  exit 0
else
  echo "FAIL"
  exit 1
fi

/* tb_core_top.sv */
////////////////////
// testbench for core_top
// random video, rtc load and count, reset sources
// and the data slot read glue
////////////////////

`timescale 1ns/1ps

module tb_core_top import core_pkg::*; ();

  localparam int tb_clks_per_sec = 9;
  localparam int video_cycles = 300;
  localparam int rtc_cycles = 50;
  localparam int test_cycles = video_cycles + rtc_cycles + 600;
  localparam int watchdog_cycles = test_cycles + 2 * reset_hold_cycles;

  logic                        clk_sys_57_12;
  logic                        reset;
  logic                        host_reset_n;
  logic [bridge_addr_w-1:0]    bridge_addr;
  logic                        bridge_wr;
  logic [bridge_addr_w-1:0]    bridge_wr_data;
  logic [31:0]                 cont1_key;
  logic                        dataslot_requestwrite;
  logic                        dataslot_allcomplete;
  logic                        rtc_valid;
  logic [bridge_addr_w-1:0]    rtc_epoch_seconds;
  logic                        core_request_read;
  logic [bridge_addr_w-1:0]    ram_data_address;
  logic [15:0]                 target_dataslot_id;
  logic [bridge_addr_w-1:0]    datatable_q;
  logic                        target_dataslot_done;
  rgb565_t                     rgb565;
  logic                        hsync;
  logic                        vsync;
  logic                        de;
  logic                        core_reset;
  logic [bridge_addr_w-1:0]    unix_seconds;
  logic                        target_dataslot_read;
  logic [bridge_addr_w-1:0]    bridge_ram_address;
  logic [datatable_addr_w-1:0] datatable_addr;
  logic [bridge_addr_w-1:0]    active_file_size;
  logic                        complete_trigger;
  rgb888_t                     video_rgb;
  logic                        video_hs;
  logic                        video_vs;
  logic                        video_de;

  logic [31:0] lfsr = 32'h79dedb61;

  // video history seen by the compare process
  rgb565_t    pix_q = '0;
  logic       de_q = 1'b0;
  logic       hs_q = 1'b0;
  logic       vs_q = 1'b0;
  logic [2:0] de_past = '0;

  core_top #(.CLKS_PER_SEC(tb_clks_per_sec)) dut_i (.*);

  initial begin
    clk_sys_57_12 = 1'b0;
    forever #50 clk_sys_57_12 = ~clk_sys_57_12;
  end

  ////////////////////
  // reference model and helpers

  function automatic logic [31:0] lfsr_step(logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  // one lfsr step per bit taken
  task automatic draw_bits(input int n, output logic [31:0] val);
    val = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_step(lfsr);
      val = {val[30:0], lfsr[0]};
    end
  endtask

  function automatic rgb888_t expand_pixel(rgb565_t p, logic on);
    logic [7:0] r;
    logic [7:0] g;
    logic [7:0] b;
    r = 8'(p[15:11]);
    g = 8'(p[10:5]);
    b = 8'(p[4:0]);
    // scale up, then refill the low bits from the top
    r = (r << 3) | (r >> 2);
    g = (g << 2) | (g >> 4);
    b = (b << 3) | (b >> 2);
    return on ? {r, g, b} : 24'h0;
  endfunction

  function automatic logic widened_de(logic [3:0] window);
    return |window;
  endfunction

  function automatic logic [31:0] rtc_expected(logic [31:0] epoch, int cycles);
    return epoch + 32'(cycles / (tb_clks_per_sec + 1));
  endfunction

  function automatic logic [datatable_addr_w-1:0] table_addr(logic [15:0] id);
    logic [16:0] full;
    full = {id, 1'b0} + 17'd1;
    return full[datatable_addr_w-1:0];
  endfunction

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("sim failed");
    $fatal(1, "stopping at the first error");
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp)
      report_failure($sformatf("ERROR at %0t: %s expected %b, got %b", $time, name, exp, act));
  endtask

  task automatic compare_word(input string name, input logic [bridge_addr_w-1:0] exp,
                              input logic [bridge_addr_w-1:0] act);
    if (act !== exp)
      report_failure($sformatf("ERROR at %0t: %s expected %h, got %h", $time, name, exp, act));
  endtask

  task automatic verify_pixel(input string name, input rgb888_t exp, input rgb888_t act);
    if (act !== exp)
      report_failure($sformatf("ERROR at %0t: %s expected %h, got %h", $time, name, exp, act));
  endtask

  task automatic match_table_addr(input string name, input logic [datatable_addr_w-1:0] exp,
                                  input logic [datatable_addr_w-1:0] act);
    if (act !== exp)
      report_failure($sformatf("ERROR at %0t: %s expected %h, got %h", $time, name, exp, act));
  endtask

  task automatic bridge_write(input logic [31:0] addr, input logic [31:0] data);
    @(posedge clk_sys_57_12);
    bridge_addr    <= addr;
    bridge_wr_data <= data;
    bridge_wr      <= 1'b1;
    @(posedge clk_sys_57_12);
    bridge_wr <= 1'b0;
  endtask

  // counts falling edges until core_reset shows the wanted level
  task automatic wait_core_reset(input logic want, input int limit, input string what,
                                 output int cycles);
    @(negedge clk_sys_57_12);
    cycles = 1;
    while (core_reset !== want && cycles < limit) begin
      @(negedge clk_sys_57_12);
      cycles++;
    end
    if (core_reset !== want) report_failure(what);
  endtask

  ////////////////////
  // video compare process

  always @(negedge clk_sys_57_12) begin
    if (!reset) begin
      verify_pixel("video_rgb", expand_pixel(pix_q, de_q), video_rgb);
      check_bit("video_hs", hs_q, video_hs);
      check_bit("video_vs", vs_q, video_vs);
      check_bit("video_de", widened_de({de_past, de}), video_de);
    end
    pix_q = rgb565;
    de_q = de;
    hs_q = hsync;
    vs_q = vsync;
    de_past = {de_past[1:0], de};
  end

  // watchdog
  initial begin
    repeat (watchdog_cycles) @(posedge clk_sys_57_12);
    report_failure("watchdog expired before the tests finished");
  end

  ////////////////////
  // stimulus

  initial begin
    logic [31:0] r;
    logic [31:0] epoch;
    logic [31:0] addr;
    logic [31:0] size;
    logic [15:0] id;
    int rise;
    int fall;
    int high;
    int pulses;
    reset = 1'b1;
    host_reset_n = 1'b1;
    bridge_addr = '0;
    bridge_wr = 1'b0;
    bridge_wr_data = '0;
    cont1_key = '0;
    dataslot_requestwrite = 1'b0;
    dataslot_allcomplete = 1'b0;
    rtc_valid = 1'b0;
    rtc_epoch_seconds = '0;
    core_request_read = 1'b0;
    ram_data_address = '0;
    target_dataslot_id = '0;
    datatable_q = '0;
    target_dataslot_done = 1'b0;
    rgb565 = '0;
    hsync = 1'b0;
    vsync = 1'b0;
    de = 1'b0;
    repeat (2) @(posedge clk_sys_57_12);
    reset <= 1'b0;

    // random pixels, syncs and de
    repeat (video_cycles) begin
      @(posedge clk_sys_57_12);
      draw_bits(16, r);
      rgb565 <= r[15:0];
      draw_bits(3, r);
      de    <= r[0];
      hsync <= r[1];
      vsync <= r[2];
    end
    @(posedge clk_sys_57_12);
    rgb565 <= '0;
    de     <= 1'b0;
    hsync  <= 1'b0;
    vsync  <= 1'b0;
    repeat (5) @(posedge clk_sys_57_12);

    // rtc load and count
    draw_bits(32, epoch);
    rtc_epoch_seconds <= epoch;
    rtc_valid <= 1'b1;
    @(posedge clk_sys_57_12);
    rtc_valid <= 1'b0;
    for (int i = 0; i < rtc_cycles; i++) begin
      @(negedge clk_sys_57_12);
      compare_word("unix_seconds", rtc_expected(epoch, i), unix_seconds);
    end

    // menu reset with its long hold
    bridge_write(reset_reg_base, 32'h1);
    wait_core_reset(1'b1, 20, "core_reset did not rise within 20 cycles of the menu write", rise);
    wait_core_reset(1'b0, reset_hold_cycles + 20, "core_reset did not fall after the hold", fall);
    if (rise + fall < reset_hold_cycles || rise + fall > reset_hold_cycles + 20)
      report_failure($sformatf("core_reset fell %0d cycles after the menu write", rise + fall));

    // start key ignored while reset-plus is off
    @(posedge clk_sys_57_12);
    cont1_key[start_key_bit] <= 1'b1;
    repeat (10) begin
      @(negedge clk_sys_57_12);
      check_bit("core_reset", 1'b0, core_reset);
    end
    @(posedge clk_sys_57_12);
    cont1_key <= '0;
    repeat (4) @(posedge clk_sys_57_12);

    bridge_write(reset_plus_addr, 32'h1);
    @(posedge clk_sys_57_12);
    cont1_key[start_key_bit] <= 1'b1;
    wait_core_reset(1'b1, 10, "start key with reset-plus on did not raise core_reset", rise);
    @(posedge clk_sys_57_12);
    cont1_key <= '0;
    wait_core_reset(1'b0, reset_hold_cycles + 20, "core_reset stuck after the start key", fall);

    // download holds the core in reset
    @(posedge clk_sys_57_12);
    dataslot_requestwrite <= 1'b1;
    @(posedge clk_sys_57_12);
    dataslot_requestwrite <= 1'b0;
    wait_core_reset(1'b1, 3, "dataslot_requestwrite did not raise core_reset", rise);
    repeat (30) begin
      @(negedge clk_sys_57_12);
      check_bit("core_reset", 1'b1, core_reset);
    end
    @(posedge clk_sys_57_12);
    dataslot_allcomplete <= 1'b1;
    @(posedge clk_sys_57_12);
    dataslot_allcomplete <= 1'b0;
    wait_core_reset(1'b0, 3, "dataslot_allcomplete did not release core_reset", fall);

    // data slot read, table lookup and completion
    draw_bits(32, addr);
    draw_bits(16, r);
    id = r[15:0];
    draw_bits(32, size);
    @(posedge clk_sys_57_12);
    core_request_read  <= 1'b1;
    ram_data_address   <= addr;
    target_dataslot_id <= id;
    datatable_q        <= size;
    @(posedge clk_sys_57_12);
    core_request_read <= 1'b0;
    ram_data_address  <= ~addr;
    high = 0;
    repeat (12) begin
      @(negedge clk_sys_57_12);
      if (target_dataslot_read) high++;
    end
    compare_word("target_dataslot_read cycles", 32'(read_stretch_cycles), 32'(high));
    compare_word("bridge_ram_address", addr, bridge_ram_address);
    match_table_addr("datatable_addr", table_addr(id), datatable_addr);
    compare_word("active_file_size", size, active_file_size);

    @(posedge clk_sys_57_12);
    target_dataslot_done <= 1'b1;
    pulses = 0;
    repeat (8) begin
      @(negedge clk_sys_57_12);
      if (complete_trigger) pulses++;
    end
    compare_word("complete_trigger pulses", 32'd1, 32'(pulses));
    @(posedge clk_sys_57_12);
    target_dataslot_done <= 1'b0;
    repeat (4) @(posedge clk_sys_57_12);

    $display("sim passed");
    $finish;
  end

endmodule

/* video_out.sv */
////////////////////
// video output stage
// rgb565 to rgb888, sync delay, blanking and de widening
////////////////////

`timescale 1ns/1ps

module video_out import core_pkg::*; (
  input  logic    clk_sys_57_12,
  input  logic    reset,
  input  rgb565_t rgb565,
  input  logic    hsync,
  input  logic    vsync,
  input  logic    de,
  output rgb888_t video_rgb,
  output logic    video_hs,
  output logic    video_vs,
  output logic    video_de
);

  rgb888_t    rgb888;
  rgb888_t    rgb_q;
  logic [2:0] de_hist;

  // replicate the top bits into the low end of each channel
  assign rgb888 = {rgb565[15:11], rgb565[15:13],
                   rgb565[10:5],  rgb565[10:9],
                   rgb565[4:0],   rgb565[4:2]};

  ////////////////////
  // one cycle delay

  always_ff @(posedge clk_sys_57_12) begin
    rgb_q <= rgb888;
  end

  always_ff @(posedge clk_sys_57_12) begin
    if (reset) begin
      video_hs <= 1'b0;
      video_vs <= 1'b0;
      de_hist  <= '0;
    end else begin
      video_hs <= hsync;
      video_vs <= vsync;
      de_hist  <= {de_hist[1:0], de};
    end
  end

  // black outside the delayed de
  assign video_rgb = de_hist[0] ? rgb_q : '0;

  // trailing de cycles give a black border column
  assign video_de = de || (de_hist != '0);

  a_blank_outside_de: assert property (@(posedge clk_sys_57_12) disable iff (reset)
    !$past(de) |-> video_rgb == '0);

endmodule
